//--- axil_sram_macros.svh
`ifndef AXIL_SRAM_MACROS_SVH
`define AXIL_SRAM_MACROS_SVH

// bus side widths
`define AXIL_ADDR_WIDTH 8
`define AXIL_DATA_WIDTH 32
`define AXIL_STRB_WIDTH (`AXIL_DATA_WIDTH / 8)

// byte offset bits dropped when a bus address becomes a word address
`define ADDR_LSB 2

// memory side geometry
`define SRAM_ADDR_WIDTH (`AXIL_ADDR_WIDTH - `ADDR_LSB)
`define SRAM_DEPTH (1 << `SRAM_ADDR_WIDTH)

`endif

//--- axil_pkg.sv
`include "axil_sram_macros.svh"

package axil_pkg;

  // byte address as seen on the aw and ar channels
  typedef logic [`AXIL_ADDR_WIDTH-1:0] axil_addr_t;

  // one bus data word
  typedef logic [`AXIL_DATA_WIDTH-1:0] axil_data_t;

  // one strobe bit per byte lane of the data word
  typedef logic [`AXIL_STRB_WIDTH-1:0] axil_strb_t;

  // response code on b and r
  // the bridge only ever returns OKAY
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_e;

endpackage

//--- sram_pkg.sv
`include "axil_sram_macros.svh"

package sram_pkg;

  // word address into the memory array
  typedef logic [`SRAM_ADDR_WIDTH-1:0] sram_addr_t;

  // memory word, same width as the bus word
  typedef logic [`AXIL_DATA_WIDTH-1:0] sram_data_t;

  // byte enables, bit i covers bits 8*i+7 down to 8*i
  typedef logic [`AXIL_STRB_WIDTH-1:0] sram_strb_t;

endpackage

//--- skid_buffer.sv
`timescale 1ns/100ps

module skid_buffer #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  i_valid,
  input  logic [DATA_WIDTH-1:0] i_data,
  output logic                  o_ready,

  input  logic                  i_ready,
  output logic [DATA_WIDTH-1:0] o_data,
  output logic                  o_valid
);

  logic                  accept;
  logic                  load;
  logic                  o_valid_next;
  logic                  skid_valid;
  logic                  skid_valid_next;
  logic [DATA_WIDTH-1:0] skid_data;

  assign accept = i_valid && o_ready;

  // output register is free, or its word leaves this cycle
  assign load = !o_valid || i_ready;

  always_comb begin
    o_valid_next    = o_valid;
    skid_valid_next = skid_valid;
    if (load) begin
      // skid word drains first, o_ready is low while it sits there
      o_valid_next    = skid_valid || accept;
      skid_valid_next = 1'b0;
    end else if (accept) begin
      skid_valid_next = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_valid    <= 1'b0;
      skid_valid <= 1'b0;
      o_ready    <= 1'b0;
    end else begin
      o_valid    <= o_valid_next;
      skid_valid <= skid_valid_next;
      o_ready    <= !skid_valid_next;
    end
  end

  always_ff @(posedge clk) begin
    if (load && (skid_valid || accept)) begin
      o_data <= skid_valid ? skid_data : i_data;
    end
    // output stalled, catch the word that was already in flight
    if (!load && accept) begin
      skid_data <= i_data;
    end
  end

endmodule

//--- axil_sram_bridge.sv
`timescale 1ns/100ps
`include "axil_sram_macros.svh"

module axil_sram_bridge (
  input  logic                   clk,
  input  logic                   rst_n,

  input  axil_pkg::axil_addr_t   i_awaddr,
  input  logic                   i_awvalid,
  output logic                   o_awready,
  input  axil_pkg::axil_data_t   i_wdata,
  input  axil_pkg::axil_strb_t   i_wstrb,
  input  logic                   i_wvalid,
  output logic                   o_wready,
  output axil_pkg::axil_resp_e   o_bresp,
  output logic                   o_bvalid,
  input  logic                   i_bready,

  input  axil_pkg::axil_addr_t   i_araddr,
  input  logic                   i_arvalid,
  output logic                   o_arready,
  output axil_pkg::axil_data_t   o_rdata,
  output axil_pkg::axil_resp_e   o_rresp,
  output logic                   o_rvalid,
  input  logic                   i_rready,

  output logic                   o_cmd_valid,
  input  logic                   i_cmd_ready,
  output sram_pkg::sram_addr_t   o_cmd_addr,
  output logic                   o_cmd_wr_en,
  output sram_pkg::sram_data_t   o_cmd_wr_data,
  output sram_pkg::sram_strb_t   o_cmd_wr_strb,
  input  logic                   i_resp_valid,
  output logic                   o_resp_ready,
  input  sram_pkg::sram_data_t   i_resp_data
);

  import axil_pkg::*;
  import sram_pkg::*;

  localparam int W_WIDTH = `AXIL_DATA_WIDTH + `AXIL_STRB_WIDTH;

  sram_addr_t ar_addr;
  logic       ar_valid;
  logic       ar_ready;

  sram_addr_t aw_addr;
  logic       aw_valid;
  logic       aw_ready;

  sram_data_t w_data;
  sram_strb_t w_strb;
  logic       w_valid;
  logic       w_ready;

  logic       r_ready;

  logic       cmd_free;
  logic       rd_ok;
  logic       wr_ok;
  logic       rd_start;
  logic       wr_start;
  logic       pri_rd;

  logic [1:0] bcnt;
  logic [1:0] bcnt_next;
  logic       wr_done;
  logic       b_done;

  // ar needs room in r as well, so a read never waits on the response path
  assign o_arready = ar_ready && r_ready;

  skid_buffer #(.DATA_WIDTH(`SRAM_ADDR_WIDTH)) u_ar_buf (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (i_arvalid && o_arready),
    .i_data  (i_araddr[`AXIL_ADDR_WIDTH-1:`ADDR_LSB]),
    .o_ready (ar_ready),
    .i_ready (rd_start),
    .o_data  (ar_addr),
    .o_valid (ar_valid)
  );

  assign o_awready = aw_ready;

  skid_buffer #(.DATA_WIDTH(`SRAM_ADDR_WIDTH)) u_aw_buf (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (i_awvalid),
    .i_data  (i_awaddr[`AXIL_ADDR_WIDTH-1:`ADDR_LSB]),
    .o_ready (aw_ready),
    .i_ready (wr_start),
    .o_data  (aw_addr),
    .o_valid (aw_valid)
  );

  // hold off w while a b response sits unclaimed
  assign o_wready = w_ready && (!o_bvalid || i_bready);

  skid_buffer #(.DATA_WIDTH(W_WIDTH)) u_w_buf (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (i_wvalid && o_wready),
    .i_data  ({i_wstrb, i_wdata}),
    .o_ready (w_ready),
    .i_ready (wr_start),
    .o_data  ({w_strb, w_data}),
    .o_valid (w_valid)
  );

  assign o_resp_ready = r_ready;
  assign o_rresp      = OKAY;

  skid_buffer #(.DATA_WIDTH(`AXIL_DATA_WIDTH)) u_r_buf (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (i_resp_valid),
    .i_data  (i_resp_data),
    .o_ready (r_ready),
    .i_ready (i_rready),
    .o_data  (o_rdata),
    .o_valid (o_rvalid)
  );

  // arbitration allows one sram op per cycle
  assign cmd_free = !o_cmd_valid || i_cmd_ready;
  assign rd_ok    = ar_valid && r_ready;
  // a write the memory takes this cycle already counts as a waiting b response
  assign wr_ok    = aw_valid && w_valid && (bcnt_next < 2'd2);

  always_comb begin
    rd_start = 1'b0;
    wr_start = 1'b0;
    if (cmd_free) begin
      if (pri_rd) begin
        rd_start = rd_ok;
        wr_start = !rd_ok && wr_ok;
      end else begin
        wr_start = wr_ok;
        rd_start = !wr_ok && rd_ok;
      end
    end
  end

  // command register holds its word until the memory takes it
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_cmd_valid <= 1'b0;
      pri_rd      <= 1'b0;
    end else if (rd_start || wr_start) begin
      o_cmd_valid <= 1'b1;
      // the side that just lost gets the next tie
      pri_rd      <= wr_start;
    end else if (i_cmd_ready) begin
      o_cmd_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_start) begin
      o_cmd_addr  <= ar_addr;
      o_cmd_wr_en <= 1'b0;
    end else if (wr_start) begin
      o_cmd_addr    <= aw_addr;
      o_cmd_wr_en   <= 1'b1;
      o_cmd_wr_data <= w_data;
      o_cmd_wr_strb <= w_strb;
    end
  end

  // a write is done once the memory accepts it
  assign wr_done  = o_cmd_valid && i_cmd_ready && o_cmd_wr_en;
  assign b_done   = o_bvalid && i_bready;
  assign o_bvalid = (bcnt != 2'd0);
  assign o_bresp  = OKAY;

  always_comb begin
    case ({wr_done, b_done})
      2'b10:   bcnt_next = bcnt + 2'd1;
      2'b01:   bcnt_next = bcnt - 2'd1;
      default: bcnt_next = bcnt;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bcnt <= 2'd0;
    end else begin
      bcnt <= bcnt_next;
    end
  end

endmodule

//--- sram_mem.sv
`timescale 1ns/100ps
`include "axil_sram_macros.svh"

module sram_mem (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic                 i_cmd_valid,
  output logic                 o_cmd_ready,
  input  sram_pkg::sram_addr_t i_cmd_addr,
  input  logic                 i_cmd_wr_en,
  input  sram_pkg::sram_data_t i_cmd_wr_data,
  input  sram_pkg::sram_strb_t i_cmd_wr_strb,

  output logic                 o_resp_valid,
  input  logic                 i_resp_ready,
  output sram_pkg::sram_data_t o_resp_data
);

  import sram_pkg::*;

  localparam int NUM_LANES = $bits(sram_strb_t);

  sram_data_t mem [`SRAM_DEPTH];

  logic cmd_fire;
  logic rd_fire;

  // no new command while a read response is still waiting
  assign o_cmd_ready = !o_resp_valid || i_resp_ready;
  assign cmd_fire    = i_cmd_valid && o_cmd_ready;
  assign rd_fire     = cmd_fire && !i_cmd_wr_en;

  // byte lane writes
  always_ff @(posedge clk) begin
    if (cmd_fire && i_cmd_wr_en) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        if (i_cmd_wr_strb[i]) begin
          mem[i_cmd_addr][8*i +: 8] <= i_cmd_wr_data[8*i +: 8];
        end
      end
    end
  end

  // read data lands one cycle after the command and holds until taken
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      o_resp_data <= mem[i_cmd_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_resp_valid <= 1'b0;
    end else if (rd_fire) begin
      o_resp_valid <= 1'b1;
    end else if (i_resp_ready) begin
      o_resp_valid <= 1'b0;
    end
  end

endmodule

//--- axil_sram_top.sv
`timescale 1ns/100ps

module axil_sram_top (
  input  logic                 clk,
  input  logic                 rst_n,

  input  axil_pkg::axil_addr_t i_awaddr,
  input  logic                 i_awvalid,
  output logic                 o_awready,
  input  axil_pkg::axil_data_t i_wdata,
  input  axil_pkg::axil_strb_t i_wstrb,
  input  logic                 i_wvalid,
  output logic                 o_wready,
  output axil_pkg::axil_resp_e o_bresp,
  output logic                 o_bvalid,
  input  logic                 i_bready,

  input  axil_pkg::axil_addr_t i_araddr,
  input  logic                 i_arvalid,
  output logic                 o_arready,
  output axil_pkg::axil_data_t o_rdata,
  output axil_pkg::axil_resp_e o_rresp,
  output logic                 o_rvalid,
  input  logic                 i_rready
);

  import sram_pkg::*;

  // bridge to memory command channel
  logic       cmd_valid;
  logic       cmd_ready;
  sram_addr_t cmd_addr;
  logic       cmd_wr_en;
  sram_data_t cmd_wr_data;
  sram_strb_t cmd_wr_strb;

  // read response channel back to the bridge
  logic       resp_valid;
  logic       resp_ready;
  sram_data_t resp_data;

  axil_sram_bridge u_bridge (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_awaddr      (i_awaddr),
    .i_awvalid     (i_awvalid),
    .o_awready     (o_awready),
    .i_wdata       (i_wdata),
    .i_wstrb       (i_wstrb),
    .i_wvalid      (i_wvalid),
    .o_wready      (o_wready),
    .o_bresp       (o_bresp),
    .o_bvalid      (o_bvalid),
    .i_bready      (i_bready),
    .i_araddr      (i_araddr),
    .i_arvalid     (i_arvalid),
    .o_arready     (o_arready),
    .o_rdata       (o_rdata),
    .o_rresp       (o_rresp),
    .o_rvalid      (o_rvalid),
    .i_rready      (i_rready),
    .o_cmd_valid   (cmd_valid),
    .i_cmd_ready   (cmd_ready),
    .o_cmd_addr    (cmd_addr),
    .o_cmd_wr_en   (cmd_wr_en),
    .o_cmd_wr_data (cmd_wr_data),
    .o_cmd_wr_strb (cmd_wr_strb),
    .i_resp_valid  (resp_valid),
    .o_resp_ready  (resp_ready),
    .i_resp_data   (resp_data)
  );

  sram_mem u_mem (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_cmd_valid   (cmd_valid),
    .o_cmd_ready   (cmd_ready),
    .i_cmd_addr    (cmd_addr),
    .i_cmd_wr_en   (cmd_wr_en),
    .i_cmd_wr_data (cmd_wr_data),
    .i_cmd_wr_strb (cmd_wr_strb),
    .o_resp_valid  (resp_valid),
    .i_resp_ready  (resp_ready),
    .o_resp_data   (resp_data)
  );

endmodule

//--- tb_clkgen.sv
`timescale 1ns/100ps

module tb_clkgen #(
  parameter int CLK_PERIOD   = 40,
  parameter int RESET_CYCLES = 16
) (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #(CLK_PERIOD / 2) o_clk = ~o_clk;
  end

  // reset is released just after an edge, like every other driven input
  initial begin
    o_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #2 o_rst_n = 1'b1;
  end

endmodule

//--- tb_axil_sram.sv
`timescale 1ns/100ps
`include "axil_sram_macros.svh"

module tb_axil_sram;

  import axil_pkg::*;
  import sram_pkg::*;

  localparam int DRIVE_DLY    = 2;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_ITER     = 16;
  localparam int NUM_OFS      = 8;
  // each test issues its requests as writes plus reads
  localparam int NUM_OPS      = 8 * NUM_ITER + 2 * NUM_OFS;
  localparam int CYCLE_LIMIT  = NUM_OPS * 20 + RESET_CYCLES;

  logic       clk;
  logic       rst_n;
  axil_addr_t awaddr;
  logic       awvalid;
  logic       awready;
  axil_data_t wdata;
  axil_strb_t wstrb;
  logic       wvalid;
  logic       wready;
  axil_resp_e bresp;
  logic       bvalid;
  logic       bready;
  axil_addr_t araddr;
  logic       arvalid;
  logic       arready;
  axil_data_t rdata;
  axil_resp_e rresp;
  logic       rvalid;
  logic       rready;

  int         seed = 32'h3df4414c;
  int         mismatches = 0;
  int         failures = 0;
  int         cycles = 0;
  axil_data_t ref_mem [`SRAM_DEPTH];
  axil_data_t exp_q [$];

  tb_clkgen #(.CLK_PERIOD(40), .RESET_CYCLES(RESET_CYCLES)) u_clkgen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  axil_sram_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_awaddr  (awaddr),
    .i_awvalid (awvalid),
    .o_awready (awready),
    .i_wdata   (wdata),
    .i_wstrb   (wstrb),
    .i_wvalid  (wvalid),
    .o_wready  (wready),
    .o_bresp   (bresp),
    .o_bvalid  (bvalid),
    .i_bready  (bready),
    .i_araddr  (araddr),
    .i_arvalid (arvalid),
    .o_arready (arready),
    .o_rdata   (rdata),
    .o_rresp   (rresp),
    .o_rvalid  (rvalid),
    .i_rready  (rready)
  );

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic axil_addr_t byte_addr(input int word, input int ofs);
    return axil_addr_t'((word << `ADDR_LSB) + ofs);
  endfunction

  // strobed lanes take the new byte, the rest keep the old one
  function automatic axil_data_t merge_bytes(input axil_data_t old_word,
                                             input axil_data_t new_word,
                                             input axil_strb_t strb);
    axil_data_t result;
    result = old_word;
    for (int i = 0; i < `AXIL_STRB_WIDTH; i++) begin
      if (strb[i]) result[8*i +: 8] = new_word[8*i +: 8];
    end
    return result;
  endfunction

  // random low stretches on a response ready
  function automatic logic next_ready(input bit stall, inout int hold);
    logic ready;
    if (stall && hold == 0 && rand_below(4) == 0) hold = 1 + rand_below(6);
    ready = (hold == 0);
    if (hold > 0) hold--;
    return ready;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    assert (got === exp) else begin
      $display("MISMATCH %s: expected %h, got %h", name, exp, got);
      mismatches++;
    end
  endtask

  task automatic expect_true(input bit cond, input string what);
    assert (cond) else begin
      $display("error: %s", what);
      failures++;
    end
  endtask

  // channel drivers enter and leave just after a rising edge
  task automatic put_aw(input axil_addr_t addr);
    awaddr  = addr;
    awvalid = 1'b1;
    do @(negedge clk); while (!awready);
    @(posedge clk);
    #DRIVE_DLY awvalid = 1'b0;
  endtask

  task automatic put_w(input axil_data_t data, input axil_strb_t strb);
    wdata  = data;
    wstrb  = strb;
    wvalid = 1'b1;
    do @(negedge clk); while (!wready);
    @(posedge clk);
    #DRIVE_DLY wvalid = 1'b0;
  endtask

  task automatic put_ar(input axil_addr_t addr);
    araddr  = addr;
    arvalid = 1'b1;
    do @(negedge clk); while (!arready);
    @(posedge clk);
    #DRIVE_DLY arvalid = 1'b0;
  endtask

  task automatic take_b(input int n, input bit stall);
    int got;
    int hold;
    got  = 0;
    hold = 0;
    while (got < n) begin
      bready = next_ready(stall, hold);
      @(negedge clk);
      if (bvalid && bready) begin
        check_value("o_bresp", OKAY, bresp);
        got++;
      end
      @(posedge clk);
      #DRIVE_DLY;
    end
    bready = 1'b0;
  endtask

  task automatic take_r(input int n, input bit stall);
    int         got;
    int         hold;
    bit         waiting;
    axil_data_t held;
    got     = 0;
    hold    = 0;
    waiting = 1'b0;
    while (got < n) begin
      rready = next_ready(stall, hold);
      @(negedge clk);
      // a response not yet taken must not change
      if (waiting) begin
        expect_true(rvalid, "rvalid dropped before the read data was taken");
        check_value("o_rdata (held)", held, rdata);
      end
      if (rvalid && rready) begin
        expect_true(exp_q.size() > 0, "read data arrived with no read outstanding");
        check_value("o_rdata", exp_q.pop_front(), rdata);
        check_value("o_rresp", OKAY, rresp);
        got++;
      end
      waiting = rvalid && !rready;
      held    = rdata;
      @(posedge clk);
      #DRIVE_DLY;
    end
    rready = 1'b0;
  endtask

  task automatic write_word(input axil_addr_t addr, input axil_data_t data,
                            input axil_strb_t strb);
    ref_mem[addr >> `ADDR_LSB] = merge_bytes(ref_mem[addr >> `ADDR_LSB], data, strb);
    fork
      put_aw(addr);
      put_w(data, strb);
      take_b(1, 1'b0);
    join
  endtask

  task automatic read_word(input axil_addr_t addr);
    exp_q.push_back(ref_mem[addr >> `ADDR_LSB]);
    fork
      put_ar(addr);
      take_r(1, 1'b0);
    join
  endtask

  // writes go to one block of words while reads hit another
  task automatic run_streams(input int wr_base, input int rd_base, input bit stall);
    axil_data_t data;
    fork
      for (int i = 0; i < NUM_ITER; i++) begin
        data = $random(seed);
        ref_mem[wr_base + i] = data;
        fork
          put_aw(byte_addr(wr_base + i, 0));
          put_w(data, 4'hf);
        join
      end
      for (int i = 0; i < NUM_ITER; i++) begin
        exp_q.push_back(ref_mem[rd_base + i]);
        put_ar(byte_addr(rd_base + i, 0));
      end
      take_b(NUM_ITER, stall);
      take_r(NUM_ITER, stall);
    join
    repeat (8) begin
      @(negedge clk);
      expect_true(!bvalid && !rvalid, "extra response after all requests were answered");
    end
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic reset_state();
    @(posedge clk);
    while (!rst_n) begin
      @(negedge clk);
      check_value("o_bvalid", 0, bvalid);
      check_value("o_rvalid", 0, rvalid);
      check_value("o_awready", 0, awready);
      check_value("o_wready", 0, wready);
      check_value("o_arready", 0, arready);
      @(posedge clk);
    end
    @(negedge clk);
    expect_true(awready && wready && arready, "ready signals did not rise after reset");
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic write_then_read();
    for (int i = 0; i < NUM_ITER; i++) write_word(byte_addr(i, 0), $random(seed), 4'hf);
    for (int i = 0; i < NUM_ITER; i++) read_word(byte_addr(i, 0));
  endtask

  task automatic partial_strobes();
    axil_strb_t strb;
    for (int i = 0; i < NUM_ITER; i++) begin
      strb = axil_strb_t'(rand_below(16));
      if (strb == 4'hf) strb = 4'h6;
      write_word(byte_addr(i, 0), $random(seed), strb);
      read_word(byte_addr(i, 0));
    end
  endtask

  task automatic offset_ignored();
    for (int i = 0; i < NUM_OFS; i++) begin
      write_word(byte_addr(NUM_ITER + i, 1 + rand_below(3)), $random(seed), 4'hf);
      read_word(byte_addr(NUM_ITER + i, 1 + rand_below(3)));
    end
  endtask

  task automatic mixed_traffic();
    run_streams(32, 0, 1'b0);
  endtask

  task automatic response_backpressure();
    run_streams(48, 32, 1'b1);
  endtask

  task automatic print_counts();
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("error: timeout after %0d cycles, the bus hung", cycles);
      failures++;
      print_counts();
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    reset_state();
    write_then_read();
    partial_strobes();
    offset_ignored();
    mixed_traffic();
    response_backpressure();
    print_counts();
    if (mismatches + failures == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+.
axil_pkg.sv
sram_pkg.sv
skid_buffer.sv
axil_sram_bridge.sv
sram_mem.sv
axil_sram_top.sv
tb_clkgen.sv
tb_axil_sram.sv

//--- Bender.yml
package:
  name: axil_sram

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - axil_pkg.sv
      - sram_pkg.sv
      - skid_buffer.sv
      - axil_sram_bridge.sv
      - sram_mem.sv
      - axil_sram_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clkgen.sv
      - tb_axil_sram.sv
